//--- source/hyper_pkg.sv
/*
 * Shared types for the HyperBus controller. Widths are fixed here: 16-bit
 * memory words, 32-bit addresses, 4-bit latency in CK cycles (3 to 7 legal).
 */
package hyper_pkg;

    // one memory word and one DQ byte
    typedef logic [15:0] hyper_word_t;
    typedef logic [7:0]  hyper_byte_t;

    // system word address, chip index sits above the chip-local bits
    typedef logic [31:0] hyper_addr_t;

    // initial latency in CK cycles
    typedef logic [3:0]  hyper_lat_t;

    // register bus
    typedef logic [31:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        CMD,
        LATENCY,
        WDATA,
        RDATA,
        DONE
    } phy_state_e;

    // register map
    localparam reg_addr_t RegLatencyOffset = 32'h0;
    localparam reg_addr_t RegStatusOffset  = 32'h4;

    // latency after reset
    localparam hyper_lat_t LatencyReset = 4'd6;

endpackage

//--- source/hyper_cfg_regs.sv
/*
 * Register-bus slave. Ready pulses one cycle after valid; the master must
 * drop valid after ready. Latency writes below 3 are raised to 3.
 */
`timescale 1ns/1ps

module hyper_cfg_regs (
    input  logic                  sys_clk,
    input  logic                  rst_i,
    input  logic                  reg_valid_i,
    input  logic                  reg_write_i,
    input  hyper_pkg::reg_addr_t  reg_addr_i,
    input  hyper_pkg::reg_data_t  reg_wdata_i,
    output logic                  reg_ready_o,
    output logic                  reg_error_o,
    output hyper_pkg::reg_data_t  reg_rdata_o,
    input  logic                  busy_i,
    output hyper_pkg::hyper_lat_t latency_o
);

    localparam hyper_pkg::hyper_lat_t LatencyMin = 4'd3;

    logic                  ready_q;
    logic                  error_q;
    hyper_pkg::reg_data_t  rdata_q;
    hyper_pkg::hyper_lat_t latency_q;

    logic                  access;
    logic                  is_latency;
    logic                  is_status;
    hyper_pkg::hyper_lat_t wr_latency;

    // a new access is taken once per valid, the cycle ready is low
    assign access     = reg_valid_i && !ready_q;
    assign is_latency = (reg_addr_i == hyper_pkg::RegLatencyOffset);
    assign is_status  = (reg_addr_i == hyper_pkg::RegStatusOffset);

    // clamp to the smallest latency the memory supports
    assign wr_latency = (reg_wdata_i[3:0] < LatencyMin) ? LatencyMin : reg_wdata_i[3:0];

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            ready_q   <= 1'b0;
            error_q   <= 1'b0;
            latency_q <= hyper_pkg::LatencyReset;
        end else begin
            ready_q <= access;
            error_q <= 1'b0;
            if (access) begin
                if (is_latency) begin
                    if (reg_write_i) begin
                        latency_q <= wr_latency;
                    end
                end else if (is_status) begin
                    // busy is read-only
                    error_q <= reg_write_i;
                end else begin
                    error_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (access) begin
            if (is_latency) begin
                rdata_q <= hyper_pkg::reg_data_t'(latency_q);
            end else if (is_status) begin
                rdata_q <= hyper_pkg::reg_data_t'(busy_i);
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign reg_ready_o = ready_q;
    assign reg_error_o = error_q;
    assign reg_rdata_o = rdata_q;
    assign latency_o   = latency_q;

    // every ready answers a valid seen the cycle before
    a_ready_needs_valid : assert property (
        @(posedge sys_clk) disable iff (rst_i)
        $rose(reg_ready_o) |-> $past(reg_valid_i)
    );

endmodule

//--- source/hyper_phy_fsm.sv
/*
 * HyperBus sequencer for single 16-bit words. One byte per sys_clk; CK is
 * toggled on the falling sys_clk edge so it lands mid-byte. No latency
 * doubling and no write masking. A read waits for the memory without limit.
 */
`timescale 1ns/1ps

module hyper_phy_fsm #(
    parameter int unsigned NumChips      = 2,
    parameter int unsigned ChipAddrWidth = 10
) (
    input  logic                   sys_clk,
    input  logic                   rst_i,
    input  logic                   mem_req_valid_i,
    input  logic                   mem_req_write_i,
    input  hyper_pkg::hyper_addr_t mem_req_addr_i,
    input  hyper_pkg::hyper_word_t mem_req_wdata_i,
    output logic                   mem_req_ready_o,
    output logic                   mem_rsp_valid_o,
    output hyper_pkg::hyper_word_t mem_rsp_rdata_o,
    input  hyper_pkg::hyper_lat_t  latency_i,
    input  logic                   rx_word_valid_i,
    input  hyper_pkg::hyper_word_t rx_word_i,
    output logic                   rx_enable_o,
    output logic [NumChips-1:0]    hyper_cs_no,
    output logic                   hyper_ck_o,
    output logic                   hyper_ck_no,
    output hyper_pkg::hyper_byte_t hyper_dq_o,
    output logic                   hyper_dq_oe_o,
    output logic                   hyper_rwds_o,
    output logic                   hyper_rwds_oe_o,
    output logic                   hyper_reset_no
);

    localparam int unsigned ChipSelWidth = (NumChips > 1) ? $clog2(NumChips) : 1;
    localparam int unsigned CmdBytes     = 6;
    localparam int unsigned CntWidth     = 5;

    hyper_pkg::phy_state_e  state_q;
    hyper_pkg::phy_state_e  state_d;
    logic [CntWidth-1:0]    cnt_q;
    logic [CntWidth-1:0]    cnt_d;
    logic [47:0]            sr_q;
    logic                   write_q;
    hyper_pkg::hyper_word_t wdata_q;
    hyper_pkg::hyper_lat_t  lat_q;
    logic [ChipSelWidth-1:0] chip_q;
    hyper_pkg::hyper_word_t rdata_q;
    logic                   ck_q;

    logic                   accept;
    logic                   active;
    hyper_pkg::hyper_addr_t local_addr;
    logic [47:0]            ca_word;
    logic [CntWidth-1:0]    lat_last;

    assign accept     = (state_q == hyper_pkg::IDLE) && mem_req_valid_i;
    assign local_addr = hyper_pkg::hyper_addr_t'(mem_req_addr_i[ChipAddrWidth-1:0]);

    // read flag, memory space, linear burst, then the split address
    assign ca_word = {!mem_req_write_i, 1'b0, 1'b1, local_addr[31:3], 13'd0, local_addr[2:0]};

    // two bytes per CK cycle of latency
    assign lat_last = {lat_q, 1'b0} - 1'b1;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q + 1'b1;
        unique case (state_q)
            hyper_pkg::IDLE: begin
                cnt_d = '0;
                if (mem_req_valid_i) begin
                    state_d = hyper_pkg::CMD;
                end
            end
            hyper_pkg::CMD: begin
                if (cnt_q == CntWidth'(CmdBytes - 1)) begin
                    state_d = hyper_pkg::LATENCY;
                    cnt_d   = '0;
                end
            end
            hyper_pkg::LATENCY: begin
                if (cnt_q == lat_last) begin
                    state_d = write_q ? hyper_pkg::WDATA : hyper_pkg::RDATA;
                    cnt_d   = '0;
                end
            end
            hyper_pkg::WDATA: begin
                if (cnt_q == CntWidth'(1)) begin
                    state_d = hyper_pkg::DONE;
                end
            end
            hyper_pkg::RDATA: begin
                cnt_d = '0;
                if (rx_word_valid_i) begin
                    state_d = hyper_pkg::DONE;
                end
            end
            hyper_pkg::DONE: state_d = hyper_pkg::IDLE;
            default: state_d = hyper_pkg::IDLE;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            state_q <= hyper_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // request capture and the outgoing byte shifter
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            sr_q    <= ca_word;
            write_q <= mem_req_write_i;
            wdata_q <= mem_req_wdata_i;
            lat_q   <= latency_i;
            chip_q  <= mem_req_addr_i[ChipAddrWidth +: ChipSelWidth];
        end else if (state_q == hyper_pkg::LATENCY && state_d == hyper_pkg::WDATA) begin
            sr_q <= {wdata_q, 32'h0};
        end else if (state_q == hyper_pkg::CMD || state_q == hyper_pkg::WDATA) begin
            sr_q <= {sr_q[39:0], 8'h00};
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state_q == hyper_pkg::RDATA && rx_word_valid_i) begin
            rdata_q <= rx_word_i;
        end
    end

    assign active = (state_q == hyper_pkg::CMD) || (state_q == hyper_pkg::LATENCY) ||
                    (state_q == hyper_pkg::WDATA) || (state_q == hyper_pkg::RDATA);

    // falling edge, so each CK edge sits in the middle of a byte
    always_ff @(negedge sys_clk) begin
        if (rst_i) begin
            ck_q <= 1'b0;
        end else if (active) begin
            ck_q <= ~ck_q;
        end else begin
            ck_q <= 1'b0;
        end
    end

    always_comb begin
        for (int i = 0; i < NumChips; i++) begin
            hyper_cs_no[i] = !(active && (chip_q == ChipSelWidth'(i)));
        end
    end

    assign hyper_ck_o      = ck_q;
    assign hyper_ck_no     = ~ck_q;
    assign hyper_dq_o      = sr_q[47:40];
    assign hyper_dq_oe_o   = (state_q == hyper_pkg::CMD) || (state_q == hyper_pkg::WDATA);
    // mask held low, both bytes always written
    assign hyper_rwds_o    = 1'b0;
    assign hyper_rwds_oe_o = (state_q == hyper_pkg::WDATA);
    assign hyper_reset_no  = !rst_i;

    assign mem_req_ready_o = (state_q == hyper_pkg::IDLE);
    assign mem_rsp_valid_o = (state_q == hyper_pkg::DONE);
    assign mem_rsp_rdata_o = rdata_q;
    assign rx_enable_o     = (state_q == hyper_pkg::RDATA);

    a_one_chip_selected : assert property (
        @(posedge sys_clk) disable iff (rst_i)
        $onehot0(~hyper_cs_no)
    );

    // memory owns DQ and RWDS while the capture block listens
    a_dq_released_in_read : assert property (
        @(posedge sys_clk) disable iff (rst_i)
        rx_enable_o |-> !hyper_dq_oe_o && !hyper_rwds_oe_o
    );

endmodule

//--- source/hyper_rx_capture.sv
/*
 * Read capture on sys_clk. RWDS must hold each level for at least one
 * sys_clk cycle; the first change after enable is taken as the high byte.
 */
`timescale 1ns/1ps

module hyper_rx_capture (
    input  logic                   sys_clk,
    input  logic                   rst_i,
    input  logic                   rx_enable_i,
    input  hyper_pkg::hyper_byte_t hyper_dq_i,
    input  logic                   hyper_rwds_i,
    output logic                   rx_word_valid_o,
    output hyper_pkg::hyper_word_t rx_word_o
);

    logic                   rwds_q;
    logic                   byte_sel_q;
    logic                   valid_q;
    hyper_pkg::hyper_byte_t high_q;
    hyper_pkg::hyper_word_t word_q;
    logic                   strobe;

    // any RWDS change while enabled marks a byte on DQ
    assign strobe = rx_enable_i && (hyper_rwds_i != rwds_q);

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            rwds_q     <= 1'b0;
            byte_sel_q <= 1'b0;
            valid_q    <= 1'b0;
        end else begin
            rwds_q  <= hyper_rwds_i;
            valid_q <= strobe && byte_sel_q;
            if (!rx_enable_i) begin
                byte_sel_q <= 1'b0;
            end else if (strobe) begin
                byte_sel_q <= ~byte_sel_q;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (strobe && !byte_sel_q) begin
            high_q <= hyper_dq_i;
        end
        if (strobe && byte_sel_q) begin
            word_q <= {high_q, hyper_dq_i};
        end
    end

    assign rx_word_valid_o = valid_q;
    assign rx_word_o       = word_q;

    // sequencer keeps enable up until it has taken the word
    a_valid_while_enabled : assert property (
        @(posedge sys_clk) disable iff (rst_i)
        rx_word_valid_o |-> rx_enable_i
    );

endmodule

//--- source/hyper_ctrl_top.sv
/*
 * HyperBus controller, single-word requests only, one transfer in flight.
 * Chip select comes from the address bits above ChipAddrWidth.
 */
`timescale 1ns/1ps

module hyper_ctrl_top #(
    parameter int unsigned NumChips      = 2,
    parameter int unsigned ChipAddrWidth = 10
) (
    input  logic                   sys_clk,
    input  logic                   rst_i,
    // register bus
    input  logic                   reg_valid_i,
    input  logic                   reg_write_i,
    input  hyper_pkg::reg_addr_t   reg_addr_i,
    input  hyper_pkg::reg_data_t   reg_wdata_i,
    output logic                   reg_ready_o,
    output logic                   reg_error_o,
    output hyper_pkg::reg_data_t   reg_rdata_o,
    // request port
    input  logic                   mem_req_valid_i,
    input  logic                   mem_req_write_i,
    input  hyper_pkg::hyper_addr_t mem_req_addr_i,
    input  hyper_pkg::hyper_word_t mem_req_wdata_i,
    output logic                   mem_req_ready_o,
    output logic                   mem_rsp_valid_o,
    output hyper_pkg::hyper_word_t mem_rsp_rdata_o,
    // HyperBus pins
    output logic [NumChips-1:0]    hyper_cs_no,
    output logic                   hyper_ck_o,
    output logic                   hyper_ck_no,
    output hyper_pkg::hyper_byte_t hyper_dq_o,
    input  hyper_pkg::hyper_byte_t hyper_dq_i,
    output logic                   hyper_dq_oe_o,
    output logic                   hyper_rwds_o,
    input  logic                   hyper_rwds_i,
    output logic                   hyper_rwds_oe_o,
    output logic                   hyper_reset_no
);

    hyper_pkg::hyper_lat_t  latency;
    logic                   rx_enable;
    logic                   rx_word_valid;
    hyper_pkg::hyper_word_t rx_word;

    hyper_cfg_regs i_hyper_cfg_regs (
        .sys_clk     ( sys_clk          ),
        .rst_i       ( rst_i            ),
        .reg_valid_i ( reg_valid_i      ),
        .reg_write_i ( reg_write_i      ),
        .reg_addr_i  ( reg_addr_i       ),
        .reg_wdata_i ( reg_wdata_i      ),
        .reg_ready_o ( reg_ready_o      ),
        .reg_error_o ( reg_error_o      ),
        .reg_rdata_o ( reg_rdata_o      ),
        // busy whenever the sequencer is not idle
        .busy_i      ( !mem_req_ready_o ),
        .latency_o   ( latency          )
    );

    hyper_phy_fsm #(
        .NumChips      ( NumChips      ),
        .ChipAddrWidth ( ChipAddrWidth )
    ) i_hyper_phy_fsm (
        .sys_clk         ( sys_clk         ),
        .rst_i           ( rst_i           ),
        .mem_req_valid_i ( mem_req_valid_i ),
        .mem_req_write_i ( mem_req_write_i ),
        .mem_req_addr_i  ( mem_req_addr_i  ),
        .mem_req_wdata_i ( mem_req_wdata_i ),
        .mem_req_ready_o ( mem_req_ready_o ),
        .mem_rsp_valid_o ( mem_rsp_valid_o ),
        .mem_rsp_rdata_o ( mem_rsp_rdata_o ),
        .latency_i       ( latency         ),
        .rx_word_valid_i ( rx_word_valid   ),
        .rx_word_i       ( rx_word         ),
        .rx_enable_o     ( rx_enable       ),
        .hyper_cs_no     ( hyper_cs_no     ),
        .hyper_ck_o      ( hyper_ck_o      ),
        .hyper_ck_no     ( hyper_ck_no     ),
        .hyper_dq_o      ( hyper_dq_o      ),
        .hyper_dq_oe_o   ( hyper_dq_oe_o   ),
        .hyper_rwds_o    ( hyper_rwds_o    ),
        .hyper_rwds_oe_o ( hyper_rwds_oe_o ),
        .hyper_reset_no  ( hyper_reset_no  )
    );

    hyper_rx_capture i_hyper_rx_capture (
        .sys_clk         ( sys_clk       ),
        .rst_i           ( rst_i         ),
        .rx_enable_i     ( rx_enable     ),
        .hyper_dq_i      ( hyper_dq_i    ),
        .hyper_rwds_i    ( hyper_rwds_i  ),
        .rx_word_valid_o ( rx_word_valid ),
        .rx_word_o       ( rx_word       )
    );

endmodule

//--- verification/hyper_ram_model.sv
/*
 * Behavioral HyperRAM for single words. Latency comes from latency_i, not
 * from the memory's own registers. Read data is returned right after the
 * latency with RWDS toggling once per byte. Unwritten words read as X.
 */
`timescale 1ns/1ps

module hyper_ram_model #(
    parameter int unsigned ChipAddrWidth = 10
) (
    input  logic                  cs_ni,
    input  logic                  ck_i,
    input  logic                  reset_ni,
    input  hyper_pkg::hyper_lat_t latency_i,
    inout  wire  [7:0]            dq_io,
    inout  wire                   rwds_io
);

    hyper_pkg::hyper_word_t mem [1 << ChipAddrWidth];
    logic [47:0]            ca;
    int unsigned            edge_cnt;
    int unsigned            data_start;
    logic                   is_read;
    logic                   drive_dq;
    logic                   rwds_out;
    hyper_pkg::hyper_byte_t dq_out;
    hyper_pkg::hyper_byte_t wr_high;
    logic [31:0]            addr;

    // six CA bytes, then two bytes per latency clock
    assign data_start = 6 + 2 * latency_i;
    assign addr       = {ca[44:16], ca[2:0]};

    // one byte per CK edge, both edges
    always @(posedge ck_i or negedge ck_i or posedge cs_ni or negedge reset_ni) begin
        if (cs_ni || !reset_ni) begin
            edge_cnt <= 0;
            is_read  <= 1'b0;
            drive_dq <= 1'b0;
            rwds_out <= 1'b0;
        end else begin
            edge_cnt <= edge_cnt + 1;
            if (edge_cnt < 6) begin
                ca <= {ca[39:0], dq_io};
                if (edge_cnt == 0) begin
                    is_read <= dq_io[7];
                end
            end else if (edge_cnt == data_start) begin
                if (is_read) begin
                    dq_out   <= mem[addr[ChipAddrWidth-1:0]][15:8];
                    rwds_out <= 1'b1;
                    drive_dq <= 1'b1;
                end else begin
                    wr_high <= dq_io;
                end
            end else if (edge_cnt == data_start + 1) begin
                if (is_read) begin
                    dq_out   <= mem[addr[ChipAddrWidth-1:0]][7:0];
                    rwds_out <= 1'b0;
                end else begin
                    mem[addr[ChipAddrWidth-1:0]] <= {wr_high, dq_io};
                end
            end
        end
    end

    // RWDS held by the memory for the whole read
    assign dq_io   = drive_dq ? dq_out : 8'hzz;
    assign rwds_io = is_read ? rwds_out : 1'bz;

endmodule

/*
 * Pad shim for one bidirectional bus. The pad floats when oe_i is low.
 */
module hyper_tristate #(
    parameter int unsigned Width = 8
) (
    input  logic             oe_i,
    input  logic [Width-1:0] out_i,
    output logic [Width-1:0] in_o,
    inout  wire  [Width-1:0] pad_io
);

    assign pad_io = oe_i ? out_i : {Width{1'bz}};
    assign in_o   = pad_io;

endmodule

//--- verification/tb_hyper_ctrl.sv
/*
 * Directed tests for the HyperBus controller with two behavioral memories.
 * Outputs are sampled on the rising edge, inputs change after it.
 */
`timescale 1ns/1ps

module tb_hyper_ctrl;

    localparam int unsigned NumChips      = 2;
    localparam int unsigned ChipAddrWidth = 10;
    localparam int unsigned ShadowBits    = ChipAddrWidth + $clog2(NumChips);
    localparam int unsigned TimeoutCycles = 20000;

    logic                   sys_clk;
    logic                   rst_i;
    logic                   reg_valid_i;
    logic                   reg_write_i;
    hyper_pkg::reg_addr_t   reg_addr_i;
    hyper_pkg::reg_data_t   reg_wdata_i;
    logic                   reg_ready_o;
    logic                   reg_error_o;
    hyper_pkg::reg_data_t   reg_rdata_o;
    logic                   mem_req_valid_i;
    logic                   mem_req_write_i;
    hyper_pkg::hyper_addr_t mem_req_addr_i;
    hyper_pkg::hyper_word_t mem_req_wdata_i;
    logic                   mem_req_ready_o;
    logic                   mem_rsp_valid_o;
    hyper_pkg::hyper_word_t mem_rsp_rdata_o;
    logic [NumChips-1:0]    hyper_cs_no;
    logic                   hyper_ck_o;
    logic                   hyper_ck_no;
    hyper_pkg::hyper_byte_t hyper_dq_o;
    hyper_pkg::hyper_byte_t hyper_dq_i;
    logic                   hyper_dq_oe_o;
    logic                   hyper_rwds_o;
    logic                   hyper_rwds_i;
    logic                   hyper_rwds_oe_o;
    logic                   hyper_reset_no;

    wire [7:0]              dq_pad;
    wire                    rwds_pad;
    hyper_pkg::hyper_lat_t  model_lat;
    hyper_pkg::hyper_word_t shadow [1 << ShadowBits];
    logic [31:0]            rng;
    int unsigned            cycle_cnt;

    hyper_ctrl_top #(
        .NumChips      ( NumChips      ),
        .ChipAddrWidth ( ChipAddrWidth )
    ) i_hyper_ctrl_top (
        .sys_clk         ( sys_clk         ),
        .rst_i           ( rst_i           ),
        .reg_valid_i     ( reg_valid_i     ),
        .reg_write_i     ( reg_write_i     ),
        .reg_addr_i      ( reg_addr_i      ),
        .reg_wdata_i     ( reg_wdata_i     ),
        .reg_ready_o     ( reg_ready_o     ),
        .reg_error_o     ( reg_error_o     ),
        .reg_rdata_o     ( reg_rdata_o     ),
        .mem_req_valid_i ( mem_req_valid_i ),
        .mem_req_write_i ( mem_req_write_i ),
        .mem_req_addr_i  ( mem_req_addr_i  ),
        .mem_req_wdata_i ( mem_req_wdata_i ),
        .mem_req_ready_o ( mem_req_ready_o ),
        .mem_rsp_valid_o ( mem_rsp_valid_o ),
        .mem_rsp_rdata_o ( mem_rsp_rdata_o ),
        .hyper_cs_no     ( hyper_cs_no     ),
        .hyper_ck_o      ( hyper_ck_o      ),
        .hyper_ck_no     ( hyper_ck_no     ),
        .hyper_dq_o      ( hyper_dq_o      ),
        .hyper_dq_i      ( hyper_dq_i      ),
        .hyper_dq_oe_o   ( hyper_dq_oe_o   ),
        .hyper_rwds_o    ( hyper_rwds_o    ),
        .hyper_rwds_i    ( hyper_rwds_i    ),
        .hyper_rwds_oe_o ( hyper_rwds_oe_o ),
        .hyper_reset_no  ( hyper_reset_no  )
    );

    hyper_tristate #(.Width(8)) i_dq_shim (
        .oe_i   ( hyper_dq_oe_o ),
        .out_i  ( hyper_dq_o    ),
        .in_o   ( hyper_dq_i    ),
        .pad_io ( dq_pad        )
    );

    hyper_tristate #(.Width(1)) i_rwds_shim (
        .oe_i   ( hyper_rwds_oe_o ),
        .out_i  ( hyper_rwds_o    ),
        .in_o   ( hyper_rwds_i    ),
        .pad_io ( rwds_pad        )
    );

    for (genvar c = 0; c < NumChips; c++) begin : g_ram
        hyper_ram_model #(.ChipAddrWidth(ChipAddrWidth)) i_hyper_ram_model (
            .cs_ni     ( hyper_cs_no[c] ),
            .ck_i      ( hyper_ck_o     ),
            .reset_ni  ( hyper_reset_no ),
            .latency_i ( model_lat      ),
            .dq_io     ( dq_pad         ),
            .rwds_io   ( rwds_pad       )
        );
    end

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (cycle_cnt == TimeoutCycles) begin
            $display("timeout: test did not finish");
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_word(input hyper_pkg::hyper_word_t got, input hyper_pkg::hyper_word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_reg(input hyper_pkg::reg_data_t got, input hyper_pkg::reg_data_t exp,
                             input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic reg_access(input logic write, input hyper_pkg::reg_addr_t addr,
                              input hyper_pkg::reg_data_t wdata,
                              output hyper_pkg::reg_data_t rdata, output logic error);
        reg_valid_i <= 1'b1;
        reg_write_i <= write;
        reg_addr_i  <= addr;
        reg_wdata_i <= wdata;
        @(posedge sys_clk);
        while (!reg_ready_o) @(posedge sys_clk);
        rdata = reg_rdata_o;
        error = reg_error_o;
        reg_valid_i <= 1'b0;
    endtask

    task automatic set_latency(input hyper_pkg::hyper_lat_t value);
        hyper_pkg::reg_data_t rdata;
        logic                 error;
        reg_access(1'b1, hyper_pkg::RegLatencyOffset, hyper_pkg::reg_data_t'(value), rdata, error);
        check_bit(error, 1'b0, "latency write error");
        // memories use the stored value, which is never below 3
        model_lat <= (value < 4'd3) ? 4'd3 : value;
    endtask

    // returns on the accepting edge and leaves valid high
    task automatic send_request(input logic write, input hyper_pkg::hyper_addr_t addr,
                                input hyper_pkg::hyper_word_t wdata);
        mem_req_valid_i <= 1'b1;
        mem_req_write_i <= write;
        mem_req_addr_i  <= addr;
        mem_req_wdata_i <= wdata;
        @(posedge sys_clk);
        while (!mem_req_ready_o) @(posedge sys_clk);
    endtask

    task automatic wait_response(output hyper_pkg::hyper_word_t rdata, output int cycles,
                                 output logic [NumChips-1:0] cs_seen);
        cycles  = 0;
        cs_seen = '0;
        do begin
            @(posedge sys_clk);
            cycles++;
            cs_seen = cs_seen | ~hyper_cs_no;
            check_bit(mem_req_ready_o, 1'b0, "ready during transfer");
            check_bit(hyper_ck_o ^ hyper_ck_no, 1'b1, "ck pair complementary");
            // rwds stays low so both bytes are written
            if (hyper_rwds_oe_o) begin
                check_bit(hyper_rwds_o, 1'b0, "rwds mask during write");
            end
        end while (!mem_rsp_valid_o);
        rdata = mem_rsp_rdata_o;
    endtask

    task automatic mem_access(input logic write, input hyper_pkg::hyper_addr_t addr,
                              input hyper_pkg::hyper_word_t wdata,
                              output hyper_pkg::hyper_word_t rdata, output int cycles,
                              output logic [NumChips-1:0] cs_seen);
        send_request(write, addr, wdata);
        mem_req_valid_i <= 1'b0;
        if (write) begin
            shadow[addr[ShadowBits-1:0]] = wdata;
        end
        wait_response(rdata, cycles, cs_seen);
    endtask

    task automatic read_check(input hyper_pkg::hyper_addr_t addr);
        hyper_pkg::hyper_word_t rdata;
        int                     cycles;
        logic [NumChips-1:0]    cs_seen;
        mem_access(1'b0, addr, '0, rdata, cycles, cs_seen);
        check_word(rdata, shadow[addr[ShadowBits-1:0]], $sformatf("read of %h", addr));
    endtask

    task automatic test_reset();
        repeat (3) @(posedge sys_clk);
        check_bit(&hyper_cs_no, 1'b1, "chip selects in reset");
        check_bit(hyper_ck_o, 1'b0, "ck in reset");
        check_bit(hyper_ck_no, 1'b1, "ck_n in reset");
        check_bit(hyper_dq_oe_o, 1'b0, "dq oe in reset");
        check_bit(hyper_rwds_oe_o, 1'b0, "rwds oe in reset");
        check_bit(hyper_reset_no, 1'b0, "memory reset in reset");
        check_bit(mem_rsp_valid_o, 1'b0, "rsp valid in reset");
        check_bit(reg_ready_o, 1'b0, "reg ready in reset");
        repeat (2) @(posedge sys_clk);
        rst_i <= 1'b0;
        @(posedge sys_clk);
        check_bit(mem_req_ready_o, 1'b1, "ready after reset");
        check_bit(hyper_reset_no, 1'b1, "memory reset released");
        check_bit(&hyper_cs_no, 1'b1, "chip selects after reset");
        check_bit(hyper_ck_o, 1'b0, "ck after reset");
        check_bit(hyper_ck_no, 1'b1, "ck_n after reset");
        check_bit(hyper_dq_oe_o, 1'b0, "dq oe after reset");
        check_bit(hyper_rwds_oe_o, 1'b0, "rwds oe after reset");
    endtask

    task automatic test_registers();
        hyper_pkg::reg_data_t rdata;
        logic                 error;
        reg_access(1'b0, hyper_pkg::RegLatencyOffset, '0, rdata, error);
        check_reg(rdata, 32'd6, "latency after reset");
        check_bit(error, 1'b0, "latency read error");
        set_latency(4'd5);
        reg_access(1'b0, hyper_pkg::RegLatencyOffset, '0, rdata, error);
        check_reg(rdata, 32'd5, "latency written 5");
        set_latency(4'd1);
        reg_access(1'b0, hyper_pkg::RegLatencyOffset, '0, rdata, error);
        check_reg(rdata, 32'd3, "latency written 1");
        reg_access(1'b1, hyper_pkg::RegStatusOffset, 32'd1, rdata, error);
        check_bit(error, 1'b1, "status write error");
        reg_access(1'b0, 32'h8, '0, rdata, error);
        check_bit(error, 1'b1, "offset 8 read error");
        check_reg(rdata, 32'd0, "offset 8 read data");
        reg_access(1'b1, 32'h8, 32'hffff_ffff, rdata, error);
        check_bit(error, 1'b1, "offset 8 write error");
    endtask

    task automatic test_write_timing(input hyper_pkg::hyper_lat_t lat);
        hyper_pkg::hyper_addr_t addr;
        hyper_pkg::hyper_word_t rdata;
        int                     cycles;
        logic [NumChips-1:0]    cs_seen;
        addr = 32'h0000_0100 + lat;
        set_latency(lat);
        mem_access(1'b1, addr, 16'h9e00 | lat, rdata, cycles, cs_seen);
        check_cycles(cycles, 6 + 2 * lat + 3, $sformatf("write at latency %0d", lat));
        read_check(addr);
    endtask

    task automatic test_chips();
        hyper_pkg::hyper_word_t rdata;
        int                     cycles;
        logic [NumChips-1:0]    cs_seen;
        // same local offset 0x3c on both chips
        mem_access(1'b1, 32'h0000_003c, 16'ha5a5, rdata, cycles, cs_seen);
        check_bit(cs_seen[0], 1'b1, "chip 0 selected");
        check_bit(cs_seen[1], 1'b0, "chip 1 idle");
        mem_access(1'b1, 32'h0000_043c, 16'h5a5a, rdata, cycles, cs_seen);
        check_bit(cs_seen[0], 1'b0, "chip 0 idle");
        check_bit(cs_seen[1], 1'b1, "chip 1 selected");
        read_check(32'h0000_003c);
        read_check(32'h0000_043c);
    endtask

    task automatic test_random();
        hyper_pkg::hyper_addr_t addrs[$];
        hyper_pkg::hyper_addr_t addr;
        hyper_pkg::hyper_word_t data;
        hyper_pkg::hyper_word_t rdata;
        int                     cycles;
        logic [NumChips-1:0]    cs_seen;
        repeat (64) begin
            rng  = xorshift32(rng);
            addr = hyper_pkg::hyper_addr_t'(rng[ShadowBits-1:0]);
            rng  = xorshift32(rng);
            data = rng[15:0];
            mem_access(1'b1, addr, data, rdata, cycles, cs_seen);
            addrs.push_back(addr);
        end
        foreach (addrs[i]) begin
            read_check(addrs[i]);
        end
    endtask

    task automatic test_backpressure();
        hyper_pkg::hyper_addr_t addr;
        hyper_pkg::hyper_word_t rdata;
        hyper_pkg::reg_data_t   status;
        logic                   error;
        int                     cycles;
        logic [NumChips-1:0]    cs_seen;
        addr = 32'h0000_0421;
        send_request(1'b1, addr, 16'hc3e1);
        shadow[addr[ShadowBits-1:0]] = 16'hc3e1;
        // a read of the same word waits behind the write
        mem_req_write_i <= 1'b0;
        reg_access(1'b0, hyper_pkg::RegStatusOffset, '0, status, error);
        check_reg(status, 32'd1, "status mid-transfer");
        check_bit(error, 1'b0, "status read error");
        wait_response(rdata, cycles, cs_seen);
        @(posedge sys_clk);
        check_bit(mem_req_ready_o, 1'b1, "ready after response");
        mem_req_valid_i <= 1'b0;
        wait_response(rdata, cycles, cs_seen);
        check_word(rdata, shadow[addr[ShadowBits-1:0]], "held read");
        reg_access(1'b0, hyper_pkg::RegStatusOffset, '0, status, error);
        check_reg(status, 32'd0, "status in idle");
    endtask

    initial begin
        rst_i           = 1'b1;
        reg_valid_i     = 1'b0;
        reg_write_i     = 1'b0;
        reg_addr_i      = '0;
        reg_wdata_i     = '0;
        mem_req_valid_i = 1'b0;
        mem_req_write_i = 1'b0;
        mem_req_addr_i  = '0;
        mem_req_wdata_i = '0;
        model_lat       = 4'd6;
        rng             = 32'h88e6868a;
        cycle_cnt       = 0;

        test_reset();
        test_registers();
        test_write_timing(4'd3);
        test_write_timing(4'd7);
        test_chips();
        test_random();
        test_backpressure();

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- project.f
source/hyper_pkg.sv
source/hyper_cfg_regs.sv
source/hyper_phy_fsm.sv
source/hyper_rx_capture.sv
source/hyper_ctrl_top.sv
verification/hyper_ram_model.sv
verification/tb_hyper_ctrl.sv

//--- Bender.yml
package:
  name: hyper_ctrl

sources:
  - files:
      - source/hyper_pkg.sv
      - source/hyper_cfg_regs.sv
      - source/hyper_phy_fsm.sv
      - source/hyper_rx_capture.sv
      - source/hyper_ctrl_top.sv
  - target: test
    files:
      - verification/hyper_ram_model.sv
      - verification/tb_hyper_ctrl.sv
